//--- sim.f
+incdir+.
soc_pkg.sv
imem_byte_banks.sv
dmem_word.sv
pim_port.sv
mem_fabric.sv
spi_target.sv
core_top.sv
tb_core_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_core_top -o tb_core_top_sim

./obj_dir/tb_core_top_sim 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

//--- tb_core_top.sv
`include "soc_macros.svh"

module tb_core_top;

    // Roughly 60 frames of about 1200 cycles each
    localparam int TIMEOUT_CYCLES = 100000;
    localparam int FRAME_BITS = `SOC_SPI_CMD_BITS + `SOC_SPI_ADDR_BITS + `SOC_SPI_DATA_BITS;

    logic           clk_i;
    logic           rv_rst_ni;
    logic           sclk_i;
    logic           cs_i;
    logic           mosi_i;
    logic           miso_o;
    soc_pkg::word_t pim_addr_o;
    soc_pkg::word_t pim_wr_o;
    soc_pkg::word_t pim_rd_i;

    // Byte-addressed picture of both memories
    soc_pkg::byte_t mem_model [soc_pkg::word_t];
    soc_pkg::word_t lfsr_q;
    int             cycle_cnt;
    int             check_cnt;
    int             error_cnt;

    core_top i_core_top (
        .clk_i      (clk_i),
        .rv_rst_ni  (rv_rst_ni),
        .sclk_i     (sclk_i),
        .cs_i       (cs_i),
        .mosi_i     (mosi_i),
        .miso_o     (miso_o),
        .pim_addr_o (pim_addr_o),
        .pim_wr_o   (pim_wr_o),
        .pim_rd_i   (pim_rd_i)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic soc_pkg::word_t rand_bits(input int n);
        soc_pkg::word_t bits;
        logic           lsb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lsb    = lfsr_q[0];
            lfsr_q = lfsr_q >> 1;
            if (lsb) begin
                lfsr_q = lfsr_q ^ 32'h8020_0003;
            end
            bits = {bits[30:0], lsb};
        end
        return bits;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_i);
        #1;
    endtask

    // Mode 0 frame, eight clocks per sclk phase
    task automatic spi_frame(input logic [7:0] cmd, input soc_pkg::word_t addr,
                             input soc_pkg::word_t wdata, output soc_pkg::word_t rdata);
        logic [FRAME_BITS-1:0] frame;
        frame = {cmd, addr, wdata};
        rdata = '0;
        cs_i  = 1'b0;
        for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            mosi_i = frame[i];
            wait_cycles(8);
            sclk_i = 1'b1;
            if (i < `SOC_SPI_DATA_BITS) begin
                rdata[i] = miso_o;
            end
            wait_cycles(8);
            sclk_i = 1'b0;
        end
        wait_cycles(8);
        cs_i   = 1'b1;
        mosi_i = 1'b0;
        wait_cycles(8);
    endtask

    task automatic spi_write(input soc_pkg::word_t addr, input soc_pkg::word_t data,
                             input soc_pkg::byte_mask_t mask);
        soc_pkg::word_t unused;
        spi_frame({1'b1, 3'b000, mask}, addr, data, unused);
    endtask

    task automatic spi_read(input soc_pkg::word_t addr, output soc_pkg::word_t rdata);
        spi_frame(8'h00, addr, '0, rdata);
    endtask

    task automatic check_word(input string name, input soc_pkg::word_t got,
                              input soc_pkg::word_t exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic void model_write(input soc_pkg::word_t addr, input soc_pkg::word_t data,
                                        input soc_pkg::byte_mask_t mask);
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                mem_model[addr + i] = data[8*i +: 8];
            end
        end
    endfunction

    // Bytes a to a+3, little-endian; DMEM drops the byte offset
    function automatic soc_pkg::word_t model_read(input soc_pkg::word_t addr);
        soc_pkg::word_t base;
        soc_pkg::word_t key;
        soc_pkg::word_t w;
        base = addr;
        if (addr[31:28] == `SOC_REGION_DMEM) begin
            base[1:0] = 2'b00;
        end
        w = '0;
        for (int i = 0; i < 4; i++) begin
            key = {base[31:14], base[13:0] + 14'(i)};
            if (mem_model.exists(key)) begin
                w[8*i +: 8] = mem_model[key];
            end else begin
                w[8*i +: 8] = 'x;
            end
        end
        return w;
    endfunction

    task automatic read_check(input soc_pkg::word_t addr);
        soc_pkg::word_t rd;
        spi_read(addr, rd);
        check_word($sformatf("rdata @%h", addr), rd, model_read(addr));
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("%s: %0d errors", name, error_cnt - errs_before);
    endtask

    task automatic test_reset_unmapped();
        int             errs;
        soc_pkg::word_t rd;
        errs = error_cnt;
        check_bit("miso_o", miso_o, 1'b0);
        check_word("pim_addr_o", pim_addr_o, '0);
        check_word("pim_wr_o", pim_wr_o, '0);
        spi_read(32'h3000_0040, rd);
        check_word("unmapped rdata", rd, `SOC_UNMAPPED_DATA);
        spi_write(32'h8000_0010, 32'h1234_5678, 4'hF);
        check_word("pim_addr_o", pim_addr_o, '0);
        check_word("pim_wr_o", pim_wr_o, '0);
        report_test("reset_unmapped", errs);
    endtask

    task automatic test_dmem();
        int             errs;
        soc_pkg::word_t base;
        errs = error_cnt;
        base = 32'h2000_0080;
        for (int i = 0; i < 3; i++) begin
            spi_write(base + 4 * i, 32'h1111_1111 * (i + 1), 4'hF);
            model_write(base + 4 * i, 32'h1111_1111 * (i + 1), 4'hF);
        end
        for (int i = 0; i < 3; i++) begin
            read_check(base + 4 * i);
        end
        spi_write(base + 4, 32'hAABB_CCDD, 4'b0101);
        model_write(base + 4, 32'hAABB_CCDD, 4'b0101);
        read_check(base + 4);
        read_check(base);
        report_test("dmem", errs);
    endtask

    task automatic test_imem();
        int             errs;
        soc_pkg::word_t base;
        soc_pkg::word_t data;
        errs = error_cnt;
        base = 32'h1000_0100;
        for (int i = 0; i < 4; i++) begin
            data = 32'h4342_4140 + 32'h0404_0404 * i;
            spi_write(base + 4 * i, data, 4'hF);
            model_write(base + 4 * i, data, 4'hF);
        end
        // Offsets 1 to 3 straddle two words
        for (int k = 0; k < 8; k++) begin
            read_check(base + 4 + k);
        end
        report_test("imem", errs);
    endtask

    task automatic test_pim();
        int             errs;
        soc_pkg::word_t rd;
        errs = error_cnt;
        spi_write(32'h4000_0010, 32'hC0DE_1234, 4'hF);
        check_word("pim_addr_o", pim_addr_o, 32'h4000_0010);
        check_word("pim_wr_o", pim_wr_o, 32'hC0DE_1234);
        spi_write(32'h2000_0100, 32'h0BAD_F00D, 4'hF);
        model_write(32'h2000_0100, 32'h0BAD_F00D, 4'hF);
        read_check(32'h2000_0100);
        check_word("pim_addr_o", pim_addr_o, 32'h4000_0010);
        check_word("pim_wr_o", pim_wr_o, 32'hC0DE_1234);
        pim_rd_i = 32'h5A5A_A5A5;
        spi_read(32'h4000_0000, rd);
        check_word("pim rdata", rd, 32'h5A5A_A5A5);
        report_test("pim", errs);
    endtask

    task automatic test_random();
        int                  errs;
        int                  pick;
        soc_pkg::word_t      written[$];
        soc_pkg::word_t      addr;
        soc_pkg::word_t      data;
        soc_pkg::byte_mask_t mask;
        logic [3:0]          region;
        errs = error_cnt;
        for (int n = 0; n < 30; n++) begin
            if (written.size() > 0 && rand_bits(1) == 1) begin
                pick = int'(rand_bits(8)) % written.size();
                read_check(written[pick]);
            end else begin
                region = (rand_bits(1) == 1) ? `SOC_REGION_IMEM : `SOC_REGION_DMEM;
                addr   = {region, 16'h0000, 4'h8, 6'(rand_bits(6)), 2'b00};
                data   = rand_bits(32);
                mask   = soc_pkg::byte_mask_t'(rand_bits(4));
                // First write to a word fills all lanes
                if (!mem_model.exists(addr)) begin
                    mask = 4'hF;
                    written.push_back(addr);
                end
                spi_write(addr, data, mask);
                model_write(addr, data, mask);
            end
        end
        report_test("random", errs);
    endtask

    initial begin
        clk_i     = 1'b0;
        rv_rst_ni = 1'b0;
        sclk_i    = 1'b0;
        cs_i      = 1'b1;
        mosi_i    = 1'b0;
        pim_rd_i  = '0;
        lfsr_q    = 32'h97da_ae6b;
        cycle_cnt = 0;
        check_cnt = 0;
        error_cnt = 0;
        wait_cycles(10);
        rv_rst_ni = 1'b1;
        wait_cycles(4);
        test_reset_unmapped();
        test_dmem();
        test_imem();
        test_pim();
        test_random();
        $display("%0d checks, %0d errors", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- core_top.sv
module core_top (
    input  logic           clk_i,
    input  logic           rv_rst_ni,
    input  logic           sclk_i,
    input  logic           cs_i,
    input  logic           mosi_i,
    output logic           miso_o,
    output soc_pkg::word_t pim_addr_o,
    output soc_pkg::word_t pim_wr_o,
    input  soc_pkg::word_t pim_rd_i
);

    // Bus from the SPI target, the only master
    soc_pkg::word_t      bus_addr;
    soc_pkg::word_t      bus_wdata;
    soc_pkg::byte_mask_t bus_mask;
    logic                bus_write;
    logic                bus_read;
    soc_pkg::word_t      bus_rdata;
    logic                bus_rvalid;

    spi_target i_spi_target (
        .clk_i        (clk_i),
        .rv_rst_ni    (rv_rst_ni),
        .sclk_i       (sclk_i),
        .cs_i         (cs_i),
        .mosi_i       (mosi_i),
        .miso_o       (miso_o),
        .bus_addr_o   (bus_addr),
        .bus_wdata_o  (bus_wdata),
        .bus_mask_o   (bus_mask),
        .bus_write_o  (bus_write),
        .bus_read_o   (bus_read),
        .bus_rdata_i  (bus_rdata),
        .bus_rvalid_i (bus_rvalid)
    );

    mem_fabric i_mem_fabric (
        .clk_i        (clk_i),
        .rv_rst_ni    (rv_rst_ni),
        .bus_addr_i   (bus_addr),
        .bus_wdata_i  (bus_wdata),
        .bus_mask_i   (bus_mask),
        .bus_write_i  (bus_write),
        .bus_read_i   (bus_read),
        .bus_rdata_o  (bus_rdata),
        .bus_rvalid_o (bus_rvalid),
        .pim_addr_o   (pim_addr_o),
        .pim_wr_o     (pim_wr_o),
        .pim_rd_i     (pim_rd_i)
    );

endmodule

//--- spi_target.sv
`include "soc_macros.svh"

module spi_target (
    input  logic                clk_i,
    input  logic                rv_rst_ni,
    input  logic                sclk_i,
    input  logic                cs_i,
    input  logic                mosi_i,
    output logic                miso_o,
    output soc_pkg::word_t      bus_addr_o,
    output soc_pkg::word_t      bus_wdata_o,
    output soc_pkg::byte_mask_t bus_mask_o,
    output logic                bus_write_o,
    output logic                bus_read_o,
    input  soc_pkg::word_t      bus_rdata_i,
    input  logic                bus_rvalid_i
);

    logic [`SOC_SYNC_STAGES-1:0]  sclk_sync_q;
    logic [`SOC_SYNC_STAGES-1:0]  cs_sync_q;
    logic [`SOC_SYNC_STAGES-1:0]  mosi_sync_q;
    logic                         sclk_prev_q;
    logic                         cs_prev_q;
    logic                         sclk_s;
    logic                         cs_s;
    logic                         mosi_s;
    logic                         sclk_rise;
    logic                         sclk_fall;
    logic                         cs_fall;

    soc_pkg::spi_state_e          state_q;
    logic [5:0]                   bit_cnt_q;
    logic [`SOC_SPI_CMD_BITS-1:0] cmd_q;
    soc_pkg::word_t               addr_q;
    soc_pkg::word_t               wdata_q;
    soc_pkg::word_t               miso_sr_q;

    // Pin synchronizers, chip select idles high
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            sclk_sync_q <= '0;
            cs_sync_q   <= '1;
            mosi_sync_q <= '0;
            sclk_prev_q <= 1'b0;
            cs_prev_q   <= 1'b1;
        end else begin
            sclk_sync_q <= {sclk_sync_q[`SOC_SYNC_STAGES-2:0], sclk_i};
            cs_sync_q   <= {cs_sync_q[`SOC_SYNC_STAGES-2:0], cs_i};
            mosi_sync_q <= {mosi_sync_q[`SOC_SYNC_STAGES-2:0], mosi_i};
            sclk_prev_q <= sclk_s;
            cs_prev_q   <= cs_s;
        end
    end

    assign sclk_s    = sclk_sync_q[`SOC_SYNC_STAGES-1];
    assign cs_s      = cs_sync_q[`SOC_SYNC_STAGES-1];
    assign mosi_s    = mosi_sync_q[`SOC_SYNC_STAGES-1];
    assign sclk_rise = sclk_s & ~sclk_prev_q;
    assign sclk_fall = ~sclk_s & sclk_prev_q;
    assign cs_fall   = ~cs_s & cs_prev_q;

    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            state_q     <= soc_pkg::IDLE;
            bit_cnt_q   <= '0;
            cmd_q       <= '0;
            bus_write_o <= 1'b0;
            bus_read_o  <= 1'b0;
        end else begin
            bus_write_o <= 1'b0;
            bus_read_o  <= 1'b0;
            if (cs_s) begin
                // Deselect aborts any frame in flight
                state_q   <= soc_pkg::IDLE;
                bit_cnt_q <= '0;
            end else begin
                case (state_q)
                    soc_pkg::IDLE: begin
                        if (cs_fall) begin
                            state_q   <= soc_pkg::CMD;
                            bit_cnt_q <= '0;
                        end
                    end
                    soc_pkg::CMD: begin
                        if (sclk_rise) begin
                            cmd_q <= {cmd_q[`SOC_SPI_CMD_BITS-2:0], mosi_s};
                            if (bit_cnt_q == 6'(`SOC_SPI_CMD_BITS - 1)) begin
                                state_q   <= soc_pkg::ADDR;
                                bit_cnt_q <= '0;
                            end else begin
                                bit_cnt_q <= bit_cnt_q + 6'd1;
                            end
                        end
                    end
                    soc_pkg::ADDR: begin
                        if (sclk_rise) begin
                            if (bit_cnt_q == 6'(`SOC_SPI_ADDR_BITS - 1)) begin
                                state_q    <= soc_pkg::DATA;
                                bit_cnt_q  <= '0;
                                // Read issued early so data is ready for the last field
                                bus_read_o <= ~cmd_q[`SOC_SPI_CMD_BITS-1];
                            end else begin
                                bit_cnt_q <= bit_cnt_q + 6'd1;
                            end
                        end
                    end
                    soc_pkg::DATA: begin
                        if (sclk_rise) begin
                            if (bit_cnt_q == 6'(`SOC_SPI_DATA_BITS - 1)) begin
                                state_q     <= soc_pkg::IDLE;
                                bit_cnt_q   <= '0;
                                bus_write_o <= cmd_q[`SOC_SPI_CMD_BITS-1];
                            end else begin
                                bit_cnt_q <= bit_cnt_q + 6'd1;
                            end
                        end
                    end
                    default: begin
                        state_q <= soc_pkg::IDLE;
                    end
                endcase
            end
        end
    end

    // Address and write data shift in on rising edges
    always_ff @(posedge clk_i) begin
        if (sclk_rise && !cs_s) begin
            if (state_q == soc_pkg::ADDR) begin
                addr_q <= {addr_q[`SOC_SPI_ADDR_BITS-2:0], mosi_s};
            end
            if (state_q == soc_pkg::DATA) begin
                wdata_q <= {wdata_q[`SOC_SPI_DATA_BITS-2:0], mosi_s};
            end
        end
    end

    // First falling edge in DATA belongs to the last address bit, so no shift there
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            miso_sr_q <= '0;
        end else if (cs_s) begin
            miso_sr_q <= '0;
        end else if (bus_rvalid_i) begin
            miso_sr_q <= bus_rdata_i;
        end else if (sclk_fall && state_q == soc_pkg::DATA && bit_cnt_q != '0) begin
            miso_sr_q <= {miso_sr_q[`SOC_SPI_DATA_BITS-2:0], 1'b0};
        end
    end

    assign miso_o      = miso_sr_q[`SOC_SPI_DATA_BITS-1];
    assign bus_addr_o  = addr_q;
    assign bus_wdata_o = wdata_q;
    assign bus_mask_o  = cmd_q[3:0];

    // Fabric answers while the data field is still being clocked
    a_rvalid_in_data: assert property (@(posedge clk_i) disable iff (!rv_rst_ni)
        bus_rvalid_i |-> state_q == soc_pkg::DATA);

endmodule

//--- mem_fabric.sv
`include "soc_macros.svh"

module mem_fabric (
    input  logic                clk_i,
    input  logic                rv_rst_ni,
    input  soc_pkg::word_t      bus_addr_i,
    input  soc_pkg::word_t      bus_wdata_i,
    input  soc_pkg::byte_mask_t bus_mask_i,
    input  logic                bus_write_i,
    input  logic                bus_read_i,
    output soc_pkg::word_t      bus_rdata_o,
    output logic                bus_rvalid_o,
    output soc_pkg::word_t      pim_addr_o,
    output soc_pkg::word_t      pim_wr_o,
    input  soc_pkg::word_t      pim_rd_i
);

    logic [3:0]     region;
    logic           hit_imem;
    logic           hit_dmem;
    logic           hit_pim;
    logic [3:0]     rd_region_q;
    soc_pkg::word_t imem_rdata;
    soc_pkg::word_t dmem_rdata;
    soc_pkg::word_t pim_rdata;

    assign region   = bus_addr_i[31:28];
    assign hit_imem = (region == `SOC_REGION_IMEM);
    assign hit_dmem = (region == `SOC_REGION_DMEM);
    assign hit_pim  = (region == `SOC_REGION_PIM);

    // Remember which target answers the pending read
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            rd_region_q  <= '0;
            bus_rvalid_o <= 1'b0;
        end else begin
            bus_rvalid_o <= bus_read_i;
            if (bus_read_i) begin
                rd_region_q <= region;
            end
        end
    end

    always_comb begin
        case (rd_region_q)
            `SOC_REGION_IMEM: bus_rdata_o = imem_rdata;
            `SOC_REGION_DMEM: bus_rdata_o = dmem_rdata;
            `SOC_REGION_PIM:  bus_rdata_o = pim_rdata;
            default:          bus_rdata_o = `SOC_UNMAPPED_DATA;
        endcase
    end

    imem_byte_banks i_imem_byte_banks (
        .clk_i     (clk_i),
        .rv_rst_ni (rv_rst_ni),
        .addr_i    (bus_addr_i),
        .wdata_i   (bus_wdata_i),
        .mask_i    (bus_mask_i),
        .write_i   (bus_write_i & hit_imem),
        .read_i    (bus_read_i & hit_imem),
        .rdata_o   (imem_rdata)
    );

    dmem_word i_dmem_word (
        .clk_i   (clk_i),
        .addr_i  (bus_addr_i),
        .wdata_i (bus_wdata_i),
        .mask_i  (bus_mask_i),
        .write_i (bus_write_i & hit_dmem),
        .read_i  (bus_read_i & hit_dmem),
        .rdata_o (dmem_rdata)
    );

    pim_port i_pim_port (
        .clk_i      (clk_i),
        .rv_rst_ni  (rv_rst_ni),
        .addr_i     (bus_addr_i),
        .wdata_i    (bus_wdata_i),
        .write_i    (bus_write_i & hit_pim),
        .read_i     (bus_read_i & hit_pim),
        .rdata_o    (pim_rdata),
        .pim_addr_o (pim_addr_o),
        .pim_wr_o   (pim_wr_o),
        .pim_rd_i   (pim_rd_i)
    );

endmodule

//--- pim_port.sv
module pim_port (
    input  logic           clk_i,
    input  logic           rv_rst_ni,
    input  soc_pkg::word_t addr_i,
    input  soc_pkg::word_t wdata_i,
    input  logic           write_i,
    input  logic           read_i,
    output soc_pkg::word_t rdata_o,
    output soc_pkg::word_t pim_addr_o,
    output soc_pkg::word_t pim_wr_o,
    input  soc_pkg::word_t pim_rd_i
);

    // Outbound registers hold until the next PIM write
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            pim_addr_o <= '0;
            pim_wr_o   <= '0;
        end else if (write_i) begin
            pim_addr_o <= addr_i;
            pim_wr_o   <= wdata_i;
        end
    end

    // Sample the external read word
    always_ff @(posedge clk_i) begin
        if (read_i) begin
            rdata_o <= pim_rd_i;
        end
    end

endmodule

//--- dmem_word.sv
`include "soc_macros.svh"

module dmem_word (
    input  logic                clk_i,
    input  soc_pkg::word_t      addr_i,
    input  soc_pkg::word_t      wdata_i,
    input  soc_pkg::byte_mask_t mask_i,
    input  logic                write_i,
    input  logic                read_i,
    output soc_pkg::word_t      rdata_o
);

    soc_pkg::word_t      mem_q [`SOC_MEM_WORDS];
    soc_pkg::bank_addr_t word_idx;

    // Byte offset bits play no part
    assign word_idx = addr_i[13:2];

    always_ff @(posedge clk_i) begin
        if (write_i) begin
            for (int i = 0; i < 4; i++) begin
                if (mask_i[i]) begin
                    mem_q[word_idx][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
        end
        if (read_i) begin
            rdata_o <= mem_q[word_idx];
        end
    end

endmodule

//--- imem_byte_banks.sv
`include "soc_macros.svh"

module imem_byte_banks (
    input  logic                clk_i,
    input  logic                rv_rst_ni,
    input  soc_pkg::word_t      addr_i,
    input  soc_pkg::word_t      wdata_i,
    input  soc_pkg::byte_mask_t mask_i,
    input  logic                write_i,
    input  logic                read_i,
    output soc_pkg::word_t      rdata_o
);

    soc_pkg::bank_addr_t word_idx;
    logic [1:0]          off_q;
    soc_pkg::byte_t      lane_rd [4];

    assign word_idx = addr_i[13:2];

    // Lanes below the byte offset fetch from the next word
    for (genvar n = 0; n < 4; n++) begin : g_bank
        soc_pkg::byte_t      mem_q [`SOC_MEM_WORDS];
        soc_pkg::bank_addr_t bank_addr;
        soc_pkg::byte_t      dout_q;

        assign bank_addr = word_idx + soc_pkg::bank_addr_t'(addr_i[1:0] > 2'(n));

        always_ff @(posedge clk_i) begin
            if (write_i && mask_i[n]) begin
                mem_q[bank_addr] <= wdata_i[8*n +: 8];
            end
            if (read_i) begin
                dout_q <= mem_q[bank_addr];
            end
        end

        assign lane_rd[n] = dout_q;
    end

    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            off_q <= '0;
        end else if (read_i) begin
            off_q <= addr_i[1:0];
        end
    end

    // Rotate bank outputs back into address order
    always_comb begin
        logic [1:0] lane;
        lane = '0;
        for (int k = 0; k < 4; k++) begin
            lane = 2'(k) + off_q;
            rdata_o[8*k +: 8] = lane_rd[lane];
        end
    end

    // Host only writes whole aligned words here
    a_write_aligned: assert property (@(posedge clk_i) disable iff (!rv_rst_ni)
        write_i |-> addr_i[1:0] == 2'b00);

endmodule

//--- soc_pkg.sv
package soc_pkg;

    // One bus word, address or data
    typedef logic [31:0] word_t;

    // One enable per byte lane
    typedef logic [3:0] byte_mask_t;

    // Word index inside a memory
    typedef logic [11:0] bank_addr_t;

    // One lane of a byte bank
    typedef logic [7:0] byte_t;

    // SPI frame progress
    typedef enum logic [1:0] {
        IDLE,
        CMD,
        ADDR,
        DATA
    } spi_state_e;

endpackage

//--- soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Address map, selected by bus address bits 31:28
`define SOC_REGION_IMEM 4'h1
`define SOC_REGION_DMEM 4'h2
`define SOC_REGION_PIM 4'h4

// Words per memory, indexed by address bits 13:2
`define SOC_MEM_WORDS 4096

// SPI frame fields, MSB first
`define SOC_SPI_CMD_BITS 8
`define SOC_SPI_ADDR_BITS 32
`define SOC_SPI_DATA_BITS 32

// Flop depth of the SPI pin synchronizers
`define SOC_SYNC_STAGES 2

// Returned by a read outside the mapped regions
`define SOC_UNMAPPED_DATA 32'hDEAD_BEEF

`endif
